//--- rtl/ll_online_sync.sv
// Online qualification and strobe generation.
// Holds off tx/rx online until each has been stable for its programmed
// delay, then pulses the strobe every delay_z_value cycles while online.

module ll_online_sync (
  input  logic                        clk_wr,
  input  logic                        arst_n,
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  logic [ll_pkg::DELAY_W-1:0]  delay_x_value,
  input  logic [ll_pkg::DELAY_W-1:0]  delay_y_value,
  input  logic [ll_pkg::DELAY_W-1:0]  delay_z_value,
  output logic                        tx_online_delay,
  output logic                        rx_online_delay,
  output logic                        tx_auto_stb
);

  import ll_pkg::*;

  // Index 0 is the tx side, index 1 the rx side
  logic [1:0]         online_in;
  logic [1:0]         online_dly;
  logic [DELAY_W-1:0] dly_val [2];
  logic [DELAY_W-1:0] dly_cnt [2];
  logic [DELAY_W-1:0] stb_cnt;
  logic               stb_last;

  assign online_in  = {rx_online, tx_online};
  assign dly_val[0] = delay_x_value;
  assign dly_val[1] = delay_y_value;

  ////////////////////////////////////////////////////////////
  // Online delay counters
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      online_dly <= '0;
      for (int i = 0; i < 2; i++) begin
        dly_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!online_in[i]) begin
          dly_cnt[i]    <= '0;
          online_dly[i] <= 1'b0;
        end else if (dly_cnt[i] == dly_val[i]) begin
          online_dly[i] <= 1'b1;
        end else begin
          dly_cnt[i] <= dly_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign tx_online_delay = online_dly[0];
  assign rx_online_delay = online_dly[1];

  ////////////////////////////////////////////////////////////
  // Periodic strobe, first pulse delay_z_value cycles after the rise
  assign stb_last = (stb_cnt == delay_z_value - DELAY_W'(1));

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      stb_cnt     <= '0;
      tx_auto_stb <= 1'b0;
    end else if (!tx_online_delay) begin
      stb_cnt     <= '0;
      tx_auto_stb <= 1'b0;
    end else begin
      stb_cnt     <= stb_last ? '0 : stb_cnt + 1'b1;
      // Dropping tx_online also kills a pulse due on the same edge
      tx_auto_stb <= stb_last & tx_online;
    end
  end

  a_stb_only_online : assert property (
    @(posedge clk_wr) disable iff (!arst_n)
    tx_auto_stb |-> tx_online_delay
  );

endmodule

//--- rtl/ll_phy_pack.sv
// PHY lane packer.
// Splits each popped beat over the two lane words and registers them with
// push, strobe and marker. Also samples the credit count returned on
// receive lane 0.

module ll_phy_pack (
  input  logic                         clk_wr,
  input  logic                         arst_n,
  input  logic                         pop,
  input  ll_pkg::ll_beat_t             pop_beat,
  input  logic                         tx_auto_stb,
  input  ll_pkg::ll_rx_lane_t          rx_phy0,
  output ll_pkg::ll_lane_t             tx_phy0,
  output ll_pkg::ll_lane_t             tx_phy1,
  output logic [ll_pkg::RX_CRED_W-1:0] rx_credit
);

  import ll_pkg::*;

  ll_lane_t lane_nxt [NUM_LANES];
  ll_lane_t lane_q   [NUM_LANES];

  ////////////////////////////////////////////////////////////
  // Lane word build
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_nxt[i]        = '0;
      lane_nxt[i].push   = pop;
      // Strobe goes out on idle words too
      lane_nxt[i].strobe = tx_auto_stb;
      if (pop) begin
        lane_nxt[i].data   = pop_beat.data[i*LANE_DATA_W +: LANE_DATA_W];
        lane_nxt[i].parity = pop_beat.parity[i*LANE_PAR_W +: LANE_PAR_W];
        lane_nxt[i].marker = pop_beat.marker;
      end
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        lane_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        lane_q[i] <= lane_nxt[i];
      end
    end
  end

  assign tx_phy0 = lane_q[0];
  assign tx_phy1 = lane_q[1];

  ////////////////////////////////////////////////////////////
  // Returned credit
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      rx_credit <= '0;
    end else begin
      rx_credit <= rx_phy0.credit;
    end
  end

endmodule

//--- rtl/ll_pkg.sv
// Shared widths and word formats for the transmit half of the logic link.
// Every RTL block imports this package, and the testbench uses the same
// types to build and check lane words.

package ll_pkg;

  ////////////////////////////////////////////////////////////
  // User beat and lane geometry
  localparam int DATA_W        = 64;
  localparam int PARITY_W      = DATA_W / 8;
  localparam int MARKER_W      = 2;
  localparam int LANE_W        = 40;
  localparam int LANE_DATA_W   = 32;
  localparam int LANE_PAR_W    = LANE_DATA_W / 8;
  localparam int NUM_LANES     = DATA_W / LANE_DATA_W;

  ////////////////////////////////////////////////////////////
  // Buffering, credits and configuration
  localparam int TX_FIFO_DEPTH = 4;
  localparam int TX_FIFO_AW    = $clog2(TX_FIFO_DEPTH);
  localparam int TX_FIFO_LVL_W = TX_FIFO_AW + 1;
  localparam int CREDIT_W      = 8;
  localparam int RX_CRED_W     = 4;
  localparam int DELAY_W       = 16;

  // Debug word is credit, then level, then pop count
  localparam int DBG_LEVEL_W   = 8;
  localparam int POP_CNT_W     = 16;
  localparam int DEBUG_W       = CREDIT_W + DBG_LEVEL_W + POP_CNT_W;

  // One accepted user beat, parity is even per byte
  typedef struct packed {
    logic [DATA_W-1:0]   data;
    logic [PARITY_W-1:0] parity;
    logic [MARKER_W-1:0] marker;
  } ll_beat_t;

  // Transmit lane word
  typedef struct packed {
    logic [LANE_DATA_W-1:0] data;
    logic [LANE_PAR_W-1:0]  parity;
    logic                   push;
    logic                   strobe;
    logic [MARKER_W-1:0]    marker;
  } ll_lane_t;

  // Receive lane word, only the credit count is used here
  typedef struct packed {
    logic [RX_CRED_W-1:0]        credit;
    logic [LANE_W-RX_CRED_W-1:0] rsvd;
  } ll_rx_lane_t;

endpackage

//--- rtl/ll_tx_credit_fifo.sv
// Transmit FIFO with credit gating.
// Beats from the user stage wait here until the link is online on both
// sides and a credit is held. Each pop spends one credit; credits
// returned by the far side are added back. Status goes to the debug port.

module ll_tx_credit_fifo (
  input  logic                         clk_wr,
  input  logic                         arst_n,
  input  logic                         stage_valid,
  input  ll_pkg::ll_beat_t             stage_beat,
  input  logic                         tx_online_delay,
  input  logic                         rx_online_delay,
  input  logic [ll_pkg::CREDIT_W-1:0]  init_st_credit,
  input  logic [ll_pkg::RX_CRED_W-1:0] rx_credit,
  output logic                         fifo_ready,
  output logic                         pop,
  output ll_pkg::ll_beat_t             pop_beat,
  output logic [ll_pkg::DEBUG_W-1:0]   tx_st_debug_status
);

  import ll_pkg::*;

  ll_beat_t                 mem [TX_FIFO_DEPTH];
  logic [TX_FIFO_AW-1:0]    wr_ptr;
  logic [TX_FIFO_AW-1:0]    rd_ptr;
  logic [TX_FIFO_LVL_W-1:0] level_q;
  logic [TX_FIFO_LVL_W-1:0] level_nxt;
  logic                     wr_en;
  logic [CREDIT_W-1:0]      cred_q;
  logic [CREDIT_W:0]        cred_sum;
  logic [POP_CNT_W-1:0]     pop_cnt_q;

  ////////////////////////////////////////////////////////////
  // Write and pop control
  assign wr_en = stage_valid & fifo_ready;

  assign pop = (level_q != '0) & (cred_q != '0) & tx_online_delay & rx_online_delay;

  assign level_nxt = level_q + TX_FIFO_LVL_W'(wr_en) - TX_FIFO_LVL_W'(pop);

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      level_q    <= '0;
      fifo_ready <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      level_q <= level_nxt;
      // Registered not-full flag, low out of reset
      fifo_ready <= (level_nxt != TX_FIFO_LVL_W'(TX_FIFO_DEPTH));
    end
  end

  // Storage
  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= stage_beat;
    end
  end

  assign pop_beat = mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // Credit counter
  // No underflow since pop needs a nonzero count
  assign cred_sum = {1'b0, cred_q} + (CREDIT_W+1)'(rx_credit) - (CREDIT_W+1)'(pop);

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      cred_q <= '0;
    end else if (!tx_online_delay) begin
      cred_q <= init_st_credit;
    end else if (cred_sum[CREDIT_W]) begin
      // Saturate at full scale
      cred_q <= '1;
    end else begin
      cred_q <= cred_sum[CREDIT_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Debug status
  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      pop_cnt_q <= '0;
    end else if (pop) begin
      pop_cnt_q <= pop_cnt_q + 1'b1;
    end
  end

  assign tx_st_debug_status = {cred_q, DBG_LEVEL_W'(level_q), pop_cnt_q};

  // A spend with nothing returned lowers the count and never wraps it
  a_pop_needs_credit : assert property (
    @(posedge clk_wr) disable iff (!arst_n)
    (pop && rx_credit == '0) |=> (cred_q < $past(cred_q))
  );

  a_no_write_full : assert property (
    @(posedge clk_wr) disable iff (!arst_n)
    wr_en |-> (level_q != TX_FIFO_LVL_W'(TX_FIFO_DEPTH))
  );

endmodule

//--- rtl/ll_tx_top.sv
// Top of the transmit half of the logic link.
// User stream in, two PHY lane words out. Credits come back on rx_phy0;
// rx_phy1 carries nothing this side needs.

module ll_tx_top (
  input  logic                        clk_wr,
  input  logic                        arst_n,

  // Link control
  input  logic                        tx_online,
  input  logic                        rx_online,
  input  logic [ll_pkg::CREDIT_W-1:0] init_st_credit,
  input  logic [ll_pkg::DELAY_W-1:0]  delay_x_value,
  input  logic [ll_pkg::DELAY_W-1:0]  delay_y_value,
  input  logic [ll_pkg::DELAY_W-1:0]  delay_z_value,

  // PHY lanes
  input  ll_pkg::ll_rx_lane_t         rx_phy0,
  input  ll_pkg::ll_rx_lane_t         rx_phy1,
  output ll_pkg::ll_lane_t            tx_phy0,
  output ll_pkg::ll_lane_t            tx_phy1,

  // User stream
  input  logic [ll_pkg::DATA_W-1:0]   user_tdata,
  input  logic                        user_tvalid,
  output logic                        user_tready,

  output logic [ll_pkg::DEBUG_W-1:0]  tx_st_debug_status
);

  import ll_pkg::*;

  ////////////////////////////////////////////////////////////
  // Interconnect
  logic                 tx_online_delay;
  logic                 rx_online_delay;
  logic                 tx_auto_stb;
  logic                 stage_valid;
  ll_beat_t             stage_beat;
  logic                 fifo_ready;
  logic                 pop;
  ll_beat_t             pop_beat;
  logic [RX_CRED_W-1:0] rx_credit;

  ll_online_sync online_sync_i (
    .clk_wr          (clk_wr),
    .arst_n          (arst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_auto_stb     (tx_auto_stb)
  );

  ll_user_stage user_stage_i (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .user_tdata  (user_tdata),
    .user_tvalid (user_tvalid),
    .fifo_ready  (fifo_ready),
    .user_tready (user_tready),
    .stage_valid (stage_valid),
    .stage_beat  (stage_beat)
  );

  ll_tx_credit_fifo tx_fifo_i (
    .clk_wr             (clk_wr),
    .arst_n             (arst_n),
    .stage_valid        (stage_valid),
    .stage_beat         (stage_beat),
    .tx_online_delay    (tx_online_delay),
    .rx_online_delay    (rx_online_delay),
    .init_st_credit     (init_st_credit),
    .rx_credit          (rx_credit),
    .fifo_ready         (fifo_ready),
    .pop                (pop),
    .pop_beat           (pop_beat),
    .tx_st_debug_status (tx_st_debug_status)
  );

  ll_phy_pack phy_pack_i (
    .clk_wr      (clk_wr),
    .arst_n      (arst_n),
    .pop         (pop),
    .pop_beat    (pop_beat),
    .tx_auto_stb (tx_auto_stb),
    .rx_phy0     (rx_phy0),
    .tx_phy0     (tx_phy0),
    .tx_phy1     (tx_phy1),
    .rx_credit   (rx_credit)
  );

endmodule

//--- rtl/ll_user_stage.sv
// User stream input slice.
// Takes beats from the tvalid/tready stream, adds byte parity and the
// running sequence marker, and offers the beat to the transmit FIFO.

module ll_user_stage (
  input  logic                      clk_wr,
  input  logic                      arst_n,
  input  logic [ll_pkg::DATA_W-1:0] user_tdata,
  input  logic                      user_tvalid,
  input  logic                      fifo_ready,
  output logic                      user_tready,
  output logic                      stage_valid,
  output ll_pkg::ll_beat_t          stage_beat
);

  import ll_pkg::*;

  logic                accept;
  logic [PARITY_W-1:0] parity_nxt;
  logic [MARKER_W-1:0] marker_q;

  // Stage is empty or drains on any edge where the FIFO has room
  assign user_tready = fifo_ready;
  assign accept      = user_tvalid & user_tready;

  // Even parity per byte
  always_comb begin
    for (int b = 0; b < PARITY_W; b++) begin
      parity_nxt[b] = ^user_tdata[b*8 +: 8];
    end
  end

  always_ff @(posedge clk_wr or negedge arst_n) begin
    if (!arst_n) begin
      stage_valid <= 1'b0;
      marker_q    <= '0;
    end else begin
      stage_valid <= accept | (stage_valid & ~fifo_ready);
      if (accept) begin
        marker_q <= marker_q + 1'b1;
      end
    end
  end

  // Beat payload
  always_ff @(posedge clk_wr) begin
    if (accept) begin
      stage_beat.data   <= user_tdata;
      stage_beat.parity <= parity_nxt;
      stage_beat.marker <= marker_q;
    end
  end

  a_stage_hold : assert property (
    @(posedge clk_wr) disable iff (!arst_n)
    (stage_valid && !fifo_ready) |=> $stable(stage_beat)
  );

endmodule

//--- sim.f
+incdir+tb
rtl/ll_pkg.sv
rtl/ll_online_sync.sv
rtl/ll_user_stage.sv
rtl/ll_tx_credit_fifo.sv
rtl/ll_phy_pack.sv
rtl/ll_tx_top.sv
tb/ll_tx_tb.sv

//--- tb/ll_tx_model.svh
// Reference model for the transmit link testbench.
// Included in the testbench module body. Keeps the expected beat queue,
// the credit count, online qualification and the strobe phase.

`ifndef LL_TX_MODEL_SVH
`define LL_TX_MODEL_SVH

ll_beat_t   exp_q [$];
logic [1:0] m_marker;
int         m_tx_on_cnt;
int         m_rx_on_cnt;
bit         m_tx_dly;
bit         m_rx_dly;
int         m_credit;
int         m_rx_reg;
int         m_since_rise;
int         m_granted;
int         m_pushes_since;
int         m_push_total;

// State right after reset release
task automatic reset_model();
  exp_q.delete();
  m_marker       = '0;
  m_tx_on_cnt    = 0;
  m_rx_on_cnt    = 0;
  m_tx_dly       = 1'b0;
  m_rx_dly       = 1'b0;
  m_credit       = 0;
  m_rx_reg       = 0;
  m_since_rise   = 0;
  m_granted      = 0;
  m_pushes_since = 0;
  m_push_total   = 0;
endtask

function automatic ll_beat_t make_beat(input logic [DATA_W-1:0] data,
                                       input logic [1:0] marker);
  ll_beat_t b;
  b.data   = data;
  b.marker = marker;
  // Even parity over each byte
  for (int i = 0; i < PARITY_W; i++) begin
    b.parity[i] = ^data[i*8 +: 8];
  end
  return b;
endfunction

task automatic record_accept(input logic [DATA_W-1:0] data);
  exp_q.push_back(make_beat(data, m_marker));
  m_marker = m_marker + 1'b1;
endtask

// One clock edge, using the inputs held over the past cycle
task automatic advance_model(input bit tx_on, input bit rx_on, input int credit_in,
                             input bit push);
  bit tx_before;
  tx_before = m_tx_dly;

  // Credits reload while tx is not qualified, otherwise count
  if (!tx_before) begin
    m_credit = INIT_CREDIT;
  end else begin
    m_credit = m_credit + m_rx_reg - int'(push);
    if (m_credit > (1 << CREDIT_W) - 1) begin
      m_credit = (1 << CREDIT_W) - 1;
    end
    m_granted      += m_rx_reg;
    m_pushes_since += int'(push);
  end
  m_push_total += int'(push);
  m_rx_reg      = credit_in;

  // Qualified once high for more than the delay
  m_tx_on_cnt = tx_on ? m_tx_on_cnt + 1 : 0;
  m_rx_on_cnt = rx_on ? m_rx_on_cnt + 1 : 0;
  m_tx_dly    = (m_tx_on_cnt > DELAY_X);
  m_rx_dly    = (m_rx_on_cnt > DELAY_Y);

  // Strobe phase counts from the tx rise
  if (m_tx_dly && tx_before) begin
    m_since_rise++;
  end else begin
    m_since_rise = 0;
  end
  if (m_tx_dly && !tx_before) begin
    m_granted      = INIT_CREDIT;
    m_pushes_since = 0;
  end
endtask

function automatic bit strobe_due();
  return m_tx_dly && (m_since_rise > 0) && ((m_since_rise % DELAY_Z) == 0);
endfunction

`endif

//--- tb/ll_tx_tb.sv
// Testbench for the link transmit top level.
// Random user beats and credit returns from a fixed seed, with one
// offline period mid-run. Lane words, strobe and debug status are
// compared every cycle against the included model.

module ll_tx_tb;

  import ll_pkg::*;

  localparam int NUM_BEATS      = 2000;
  localparam int CYCLE_LIMIT    = NUM_BEATS * 10;
  localparam int DELAY_X        = 5;
  localparam int DELAY_Y        = 7;
  localparam int DELAY_Z        = 9;
  localparam int INIT_CREDIT    = 3;
  localparam int OFFLINE_CYCLES = 40;

  logic                 clk_wr;
  logic                 arst_n;
  logic                 tx_online;
  logic                 rx_online;
  logic [CREDIT_W-1:0]  init_st_credit;
  logic [DELAY_W-1:0]   delay_x_value;
  logic [DELAY_W-1:0]   delay_y_value;
  logic [DELAY_W-1:0]   delay_z_value;
  ll_rx_lane_t          rx_phy0;
  ll_rx_lane_t          rx_phy1;
  ll_lane_t             tx_phy0;
  ll_lane_t             tx_phy1;
  logic [DATA_W-1:0]    user_tdata;
  logic                 user_tvalid;
  logic                 user_tready;
  logic [DEBUG_W-1:0]   tx_st_debug_status;

  integer seed;
  int     cycle;
  int     accepted;
  int     value_errs;
  int     other_errs;
  int     offline_left;
  int     starved_accepts;
  int     tready_low_cycles;
  bit     toggle_done;
  bit     done;
  bit     fall_seen;
  bit     offer_taken;

  `include "ll_tx_model.svh"

  ll_tx_top dut_i (
    .clk_wr             (clk_wr),
    .arst_n             (arst_n),
    .tx_online          (tx_online),
    .rx_online          (rx_online),
    .init_st_credit     (init_st_credit),
    .delay_x_value      (delay_x_value),
    .delay_y_value      (delay_y_value),
    .delay_z_value      (delay_z_value),
    .rx_phy0            (rx_phy0),
    .rx_phy1            (rx_phy1),
    .tx_phy0            (tx_phy0),
    .tx_phy1            (tx_phy1),
    .user_tdata         (user_tdata),
    .user_tvalid        (user_tvalid),
    .user_tready        (user_tready),
    .tx_st_debug_status (tx_st_debug_status)
  );

  initial begin
    clk_wr = 1'b0;
    forever #4 clk_wr = ~clk_wr;
  end

  task automatic expect_eq(input string name, input logic [63:0] got,
                           input logic [63:0] want);
    assert (got === want) else begin
      $display("Fail %s: got 0x%0h expected 0x%0h", name, got, want);
      value_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Lane words from the edge just past, against the model before it
  task automatic lane_checks();
    ll_beat_t head;
    // Lane register puts the strobe one cycle behind the model's phase
    expect_eq("tx_phy0.strobe", tx_phy0.strobe, strobe_due());
    expect_eq("tx_phy1.strobe", tx_phy1.strobe, strobe_due());
    expect_eq("tx_phy1.push", tx_phy1.push, tx_phy0.push);
    if (tx_phy0.push) begin
      assert (m_tx_dly && m_rx_dly) else begin
        $display("Push while the link was not qualified online");
        other_errs++;
      end
      assert (m_credit > 0) else begin
        $display("Push with no credit held");
        other_errs++;
      end
      assert (exp_q.size() > 0) else begin
        $display("Push with no accepted beat outstanding");
        other_errs++;
      end
      if (exp_q.size() > 0) begin
        head = exp_q.pop_front();
        expect_eq("tx_phy0.data", tx_phy0.data, head.data[31:0]);
        expect_eq("tx_phy1.data", tx_phy1.data, head.data[63:32]);
        expect_eq("tx_phy0.parity", tx_phy0.parity, head.parity[3:0]);
        expect_eq("tx_phy1.parity", tx_phy1.parity, head.parity[7:4]);
        expect_eq("tx_phy0.marker", tx_phy0.marker, head.marker);
        expect_eq("tx_phy1.marker", tx_phy1.marker, head.marker);
      end
    end else begin
      // Idle words carry no payload
      expect_eq("tx_phy0 payload", {tx_phy0.data, tx_phy0.parity, tx_phy0.marker}, '0);
      expect_eq("tx_phy1 payload", {tx_phy1.data, tx_phy1.parity, tx_phy1.marker}, '0);
    end
  endtask

  // Checks against the model after the edge
  task automatic cycle_checks();
    int dbg_level;
    expect_eq("debug credit", tx_st_debug_status[DEBUG_W-1 -: CREDIT_W], m_credit);
    expect_eq("debug pop count", tx_st_debug_status[POP_CNT_W-1:0],
              POP_CNT_W'(m_push_total));
    // Outstanding beats sit in the FIFO, plus at most one in the stage
    dbg_level = int'(tx_st_debug_status[POP_CNT_W +: DBG_LEVEL_W]);
    assert (dbg_level <= exp_q.size() && dbg_level + 1 >= exp_q.size()
            && dbg_level <= TX_FIFO_DEPTH) else begin
      $display("Fail debug level: got 0x%0h with 0x%0h beats outstanding",
               dbg_level, exp_q.size());
      value_errs++;
    end
    assert (m_pushes_since <= m_granted) else begin
      $display("More pushes than credits granted since the link came online");
      other_errs++;
    end
    if (m_credit > 0) begin
      starved_accepts = 0;
    end
    if (!user_tready && m_tx_dly && m_credit == 0) begin
      fall_seen = 1'b1;
    end
    // Ready must come back soon once a credit is held
    if (!user_tready && m_tx_dly && m_rx_dly && m_credit > 0) begin
      tready_low_cycles++;
    end else begin
      tready_low_cycles = 0;
    end
    assert (tready_low_cycles <= 3) else begin
      $display("user_tready stayed low although credit was available");
      other_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus for the next edge
  task automatic drive_inputs();
    int r_sel;
    int r_cred;
    if (!toggle_done && accepted >= NUM_BEATS / 2) begin
      toggle_done  = 1'b1;
      offline_left = OFFLINE_CYCLES;
    end
    if (offline_left > 0) begin
      offline_left--;
      tx_online = 1'b0;
      rx_online = 1'b0;
    end else begin
      tx_online = 1'b1;
      rx_online = 1'b1;
    end

    // Credit returns, withheld in the last quarter of each 400 cycles
    r_sel  = $random(seed);
    r_cred = $random(seed);
    if ((cycle % 400) >= 300 && accepted < NUM_BEATS) begin
      rx_phy0.credit = '0;
    end else if (r_sel & 1) begin
      rx_phy0.credit = RX_CRED_W'(r_cred & 3);
    end else begin
      rx_phy0.credit = '0;
    end

    // Data holds while a beat waits for ready
    if (accepted >= NUM_BEATS) begin
      user_tvalid = 1'b0;
    end else if (!user_tvalid || offer_taken) begin
      user_tvalid = ($random(seed) & 3) != 0;
      user_tdata  = {$random(seed), $random(seed)};
    end
    offer_taken = user_tvalid && user_tready;
    if (offer_taken) begin
      if (m_credit == 0) begin
        starved_accepts++;
      end
      assert (starved_accepts <= TX_FIFO_DEPTH + 2) else begin
        $display("user_tready failed to drop while credits were withheld");
        other_errs++;
      end
      record_accept(user_tdata);
      accepted++;
    end
  endtask

  initial begin
    seed              = 84;
    cycle             = 0;
    accepted          = 0;
    value_errs        = 0;
    other_errs        = 0;
    offline_left      = 0;
    starved_accepts   = 0;
    tready_low_cycles = 0;
    toggle_done       = 1'b0;
    done              = 1'b0;
    fall_seen         = 1'b0;
    offer_taken       = 1'b0;
    arst_n            = 1'b0;
    tx_online         = 1'b0;
    rx_online         = 1'b0;
    init_st_credit    = CREDIT_W'(INIT_CREDIT);
    delay_x_value     = DELAY_W'(DELAY_X);
    delay_y_value     = DELAY_W'(DELAY_Y);
    delay_z_value     = DELAY_W'(DELAY_Z);
    rx_phy0           = '0;
    rx_phy1           = '0;
    user_tdata        = '0;
    user_tvalid       = 1'b0;
    reset_model();

    repeat (16) @(posedge clk_wr);
    @(negedge clk_wr);
    arst_n    = 1'b1;
    tx_online = 1'b1;
    rx_online = 1'b1;

    while (!done && cycle < CYCLE_LIMIT) begin
      @(negedge clk_wr);
      cycle++;
      lane_checks();
      advance_model(tx_online, rx_online, rx_phy0.credit, tx_phy0.push);
      cycle_checks();
      drive_inputs();
      done = (accepted == NUM_BEATS) && (exp_q.size() == 0);
    end

    if (!done) begin
      $display("Timeout after %0d cycles with %0d beats outstanding", cycle, exp_q.size());
      other_errs++;
    end else begin
      expect_eq("push count", m_push_total, NUM_BEATS);
      assert (fall_seen) else begin
        $display("user_tready never dropped under credit back-pressure");
        other_errs++;
      end
    end
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
